/* verilog/mandel_config.svh */
/*
 * Mandelbrot renderer build constants.
 * PE count, datapath widths and fixed-point format.
 */

`ifndef MANDEL_CONFIG_SVH
`define MANDEL_CONFIG_SVH

// Processing elements working on one row group.
`define NUM_PE        4
`define DEPTH_W       32

// Sign-magnitude fixed point, magnitude part.
`define FIX_MAG_W     32
`define FIX_INT_BITS  3
`define FIX_FRAC_BITS (`FIX_MAG_W - `FIX_INT_BITS)

// Configuration word, eight doubles.
`define CFG_W         512
`define CFG_FIELD_W   64

`endif

/* verilog/fixed_pkg.sv */
/*
 * Fixed-point arithmetic for the Mandelbrot datapath.
 * Sign-magnitude values with 3 integer and 29 fraction bits.
 */

`include "mandel_config.svh"

package fixed_pkg;

   typedef logic [`FIX_MAG_W:0]     fixed_t;
   typedef logic [`FIX_MAG_W-1:0]   fixed_mag_t;
   typedef logic [`CFG_FIELD_W-1:0] double_t;

   // 4.0, the escape radius squared.
   localparam fixed_t FIX_FOUR = {1'b0, fixed_mag_t'(4) << `FIX_FRAC_BITS};

   // Multiply. Top integer bits and low fraction bits fall off.
   function automatic fixed_t fixed_mul(input fixed_t v1, input fixed_t v2);
      logic [2*`FIX_MAG_W-1:0] prod;
      prod = v1[`FIX_MAG_W-1:0] * v2[`FIX_MAG_W-1:0];
      fixed_mul = {v1[`FIX_MAG_W] ^ v2[`FIX_MAG_W], prod[`FIX_FRAC_BITS +: `FIX_MAG_W]};
   endfunction

   // Sign-magnitude to ones' complement.
   // The +1 of a true twos' complement is below the LSB weight, so skipped.
   // Same mapping works in both directions.
   function automatic fixed_t fixed_sign_conv(input fixed_t f);
      fixed_sign_conv = f[`FIX_MAG_W] ? {1'b1, ~f[`FIX_MAG_W-1:0]} : f;
   endfunction

   // v1 + v2, or v1 - v2 when sub is set.
   function automatic fixed_t fixed_add(input fixed_t v1, input fixed_t v2, input logic sub);
      fixed_t sum;
      sum = fixed_sign_conv(v1) +
            fixed_sign_conv({v2[`FIX_MAG_W] ^ sub, v2[`FIX_MAG_W-1:0]});
      fixed_add = fixed_sign_conv(sum);
   endfunction

   // IEEE double to fixed.
   // Hidden one plus top mantissa bits, shifted by the unbiased exponent.
   function automatic fixed_t real_to_fixed(input double_t d);
      fixed_mag_t mant;
      int         shift;
      mant  = {1'b1, d[51 -: `FIX_MAG_W-1]};
      shift = 1023 + `FIX_INT_BITS - 1 - int'(d[62:52]);
      if (d[62:52] == '0) begin
         // Zero and denormals.
         real_to_fixed = {d[63], {`FIX_MAG_W{1'b0}}};
      end else if (shift < 0) begin
         // Out of range, clamp to largest magnitude.
         real_to_fixed = {d[63], {`FIX_MAG_W{1'b1}}};
      end else begin
         real_to_fixed = {d[63], mant >> shift};
      end
   endfunction

endpackage

/* verilog/frame_pkg.sv */
/*
 * Frame-level types for the Mandelbrot renderer.
 * Depth, pixel index, config word and run state.
 */

`include "mandel_config.svh"

package frame_pkg;

   // Iteration count of one pixel.
   typedef logic [`DEPTH_W-1:0] depth_t;

   // Column or row index, same width as depth.
   typedef logic [`DEPTH_W-1:0] pix_idx_t;

   // Raw configuration word.
   // Doubles from the bottom: min x, min y, step x, step y,
   // width, height, max depth, unused.
   typedef logic [`CFG_W-1:0] cfg_word_t;

   // Frame scan state.
   typedef enum logic {
      FRAME_IDLE,
      FRAME_RUN
   } frame_state_t;

endpackage

/* verilog/view_config.sv */
/*
 * View configuration register.
 * Splits the config word and holds view, size and max depth.
 */

`timescale 1ns/1ps

`include "mandel_config.svh"

module view_config
   import fixed_pkg::*, frame_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      s_tvalid,
   input  cfg_word_t s_tdata,
   output fixed_t    min_x,
   output fixed_t    min_y,
   output fixed_t    step_x,
   output fixed_t    step_y,
   output pix_idx_t  size_x,
   output pix_idx_t  size_y,
   output depth_t    max_depth
);

   double_t f_min_x, f_min_y, f_step_x, f_step_y;
   double_t f_size_x, f_size_y, f_depth;

   // Field split. Top field is unused.
   assign f_min_x  = s_tdata[0*`CFG_FIELD_W +: `CFG_FIELD_W];
   assign f_min_y  = s_tdata[1*`CFG_FIELD_W +: `CFG_FIELD_W];
   assign f_step_x = s_tdata[2*`CFG_FIELD_W +: `CFG_FIELD_W];
   assign f_step_y = s_tdata[3*`CFG_FIELD_W +: `CFG_FIELD_W];
   assign f_size_x = s_tdata[4*`CFG_FIELD_W +: `CFG_FIELD_W];
   assign f_size_y = s_tdata[5*`CFG_FIELD_W +: `CFG_FIELD_W];
   assign f_depth  = s_tdata[6*`CFG_FIELD_W +: `CFG_FIELD_W];

   // Load on strobe; sizes and depth are plain integers in the low bits.
   always_ff @(posedge clk) begin
      if (reset) begin
         min_x     <= '0;
         min_y     <= '0;
         step_x    <= '0;
         step_y    <= '0;
         size_x    <= '0;
         size_y    <= '0;
         max_depth <= '0;
      end else if (s_tvalid) begin
         min_x     <= real_to_fixed(f_min_x);
         min_y     <= real_to_fixed(f_min_y);
         step_x    <= real_to_fixed(f_step_x);
         step_y    <= real_to_fixed(f_step_y);
         size_x    <= f_size_x[`DEPTH_W-1:0];
         size_y    <= f_size_y[`DEPTH_W-1:0];
         max_depth <= f_depth[`DEPTH_W-1:0];
      end
   end

endmodule

/* verilog/frame_sequencer.sv */
/*
 * Frame sequencer.
 * Run FSM with column-group and row scan counters.
 */

`timescale 1ns/1ps

`include "mandel_config.svh"

module frame_sequencer
   import frame_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   input  logic     group_done,
   input  pix_idx_t size_x,
   input  pix_idx_t size_y,
   output pix_idx_t col_base,
   output pix_idx_t row,
   output logic     scan_clear
);

   frame_state_t state;
   logic         col_wrap;
   logic         row_wrap;
   logic         last_group;

   // ====================
   // Scan position
   // ====================

   // Last column group of the row.
   assign col_wrap   = (col_base + `NUM_PE) >= size_x;
   // Last row of the frame.
   assign row_wrap   = (row + 1'b1) >= size_y;
   assign last_group = col_wrap && row_wrap;

   // PEs hold depth at zero outside a frame.
   assign scan_clear = (state != FRAME_RUN);

   // ====================
   // FSM and counters
   // ====================

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= FRAME_IDLE;
         col_base <= '0;
         row      <= '0;
      end else begin
         unique case (state)
            FRAME_IDLE: begin
               col_base <= '0;
               row      <= '0;
               if (start) begin
                  state <= FRAME_RUN;
               end
            end
            FRAME_RUN: begin
               if (group_done) begin
                  if (last_group) begin
                     // Frame finished.
                     state    <= FRAME_IDLE;
                     col_base <= '0;
                     row      <= '0;
                  end else if (col_wrap) begin
                     col_base <= '0;
                     row      <= row + 1'b1;
                  end else begin
                     col_base <= col_base + `NUM_PE;
                  end
               end
            end
            default: state <= FRAME_IDLE;
         endcase
      end
   end

endmodule

/* verilog/pixel_coord.sv */
/*
 * Pixel to complex plane mapping.
 * c = min + step * index, per axis.
 */

`timescale 1ns/1ps

`include "mandel_config.svh"

module pixel_coord
   import fixed_pkg::*, frame_pkg::*;
(
   input  pix_idx_t col,
   input  pix_idx_t row,
   input  fixed_t   min_x,
   input  fixed_t   min_y,
   input  fixed_t   step_x,
   input  fixed_t   step_y,
   output fixed_t   c_re,
   output fixed_t   c_im
);

   fixed_mag_t off_x;
   fixed_mag_t off_y;

   // Offset from the corner, magnitude only.
   // Steps count as positive; the scan runs right and down.
   assign off_x = step_x[`FIX_MAG_W-1:0] * col;
   assign off_y = step_y[`FIX_MAG_W-1:0] * row;

   assign c_re = fixed_add(min_x, {1'b0, off_x}, 1'b0);
   assign c_im = fixed_add(min_y, {1'b0, off_y}, 1'b0);

endmodule

/* verilog/mandel_pe.sv */
/*
 * Mandelbrot processing element.
 * Iterates z = z^2 + c one step per cycle for one pixel.
 */

`timescale 1ns/1ps

`include "mandel_config.svh"

module mandel_pe
   import fixed_pkg::*, frame_pkg::*;
#(
   parameter int PE_IDX = 0
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     scan_clear,
   input  logic     group_done,
   input  pix_idx_t col_base,
   input  pix_idx_t row,
   input  fixed_t   min_x,
   input  fixed_t   min_y,
   input  fixed_t   step_x,
   input  fixed_t   step_y,
   input  depth_t   max_depth,
   output logic     pix_done,
   output depth_t   depth
);

   pix_idx_t col;
   fixed_t   c_re_init, c_im_init;
   fixed_t   c_re, c_im;
   fixed_t   a, b;
   fixed_t   a_sq, b_sq, ab, two_ab;
   fixed_t   sq_sum, sq_diff;
   fixed_t   a_next, b_next;
   logic     init_pix;
   logic     escape_sum, escape_mag, at_max;

   // ====================
   // Pixel coordinate
   // ====================

   assign col = col_base + pix_idx_t'(PE_IDX);

   pixel_coord u_pixel_coord (
      .col    (col),
      .row    (row),
      .min_x  (min_x),
      .min_y  (min_y),
      .step_x (step_x),
      .step_y (step_y),
      .c_re   (c_re_init),
      .c_im   (c_im_init)
   );

   // Depth 0 is the load cycle.
   assign init_pix = (depth == '0);

   // ====================
   // Escape test
   // ====================

   assign a_sq   = fixed_mul(a, a);
   assign b_sq   = fixed_mul(b, b);
   assign sq_sum = fixed_add(a_sq, b_sq, 1'b0);

   // a^2 + b^2 >= 4.0.
   assign escape_sum = !sq_sum[`FIX_MAG_W] &&
                       (sq_sum[`FIX_MAG_W-1:0] >= FIX_FOUR[`FIX_MAG_W-1:0]);
   // |a| or |b| >= 2.0, catches squares that overflowed.
   assign escape_mag = |{a[`FIX_MAG_W-1 -: `FIX_INT_BITS-1],
                         b[`FIX_MAG_W-1 -: `FIX_INT_BITS-1]};
   assign at_max     = (depth == max_depth);

   // Never done on the load cycle.
   assign pix_done = !init_pix && (escape_sum || escape_mag || at_max);

   // ====================
   // Next z
   // ====================

   assign sq_diff = fixed_add(a_sq, b_sq, 1'b1);
   assign ab      = fixed_mul(a, b);
   assign two_ab  = {ab[`FIX_MAG_W], ab[`FIX_MAG_W-1:0] << 1};

   // Load z = c, else a^2 - b^2 + re, 2ab + im.
   assign a_next = init_pix ? c_re_init : fixed_add(sq_diff, c_re, 1'b0);
   assign b_next = init_pix ? c_im_init : fixed_add(two_ab, c_im, 1'b0);

   // Hold c for the rest of the pixel.
   always_ff @(posedge clk) begin
      if (init_pix) begin
         c_re <= c_re_init;
         c_im <= c_im_init;
      end
   end

   // z freezes once done.
   always_ff @(posedge clk) begin
      if (!pix_done) begin
         a <= a_next;
         b <= b_next;
      end
   end

   // Depth counter; group completion restarts the next pixel.
   always_ff @(posedge clk) begin
      if (reset || scan_clear || group_done) begin
         depth <= '0;
      end else if (!pix_done) begin
         depth <= depth + 1'b1;
      end
   end

endmodule

/* verilog/mandel_top.sv */
/*
 * Mandelbrot renderer top level.
 * Config register, frame sequencer and a row of PEs.
 */

`timescale 1ns/1ps

`include "mandel_config.svh"

module mandel_top
   import fixed_pkg::*, frame_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          start,
   input  logic                          s_tvalid,
   input  cfg_word_t                     s_tdata,
   output logic                          m_tvalid,
   output logic [`NUM_PE*`DEPTH_W-1:0]   m_tdata
);

   fixed_t               min_x, min_y, step_x, step_y;
   pix_idx_t             size_x, size_y;
   depth_t               max_depth;
   pix_idx_t             col_base, row;
   logic                 scan_clear;
   logic                 group_done;
   logic [`NUM_PE-1:0]   pix_done;
   depth_t               pe_depth [`NUM_PE];

   view_config u_view_config (
      .clk       (clk),
      .reset     (reset),
      .s_tvalid  (s_tvalid),
      .s_tdata   (s_tdata),
      .min_x     (min_x),
      .min_y     (min_y),
      .step_x    (step_x),
      .step_y    (step_y),
      .size_x    (size_x),
      .size_y    (size_y),
      .max_depth (max_depth)
   );

   frame_sequencer u_frame_sequencer (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .group_done (group_done),
      .size_x     (size_x),
      .size_y     (size_y),
      .col_base   (col_base),
      .row        (row),
      .scan_clear (scan_clear)
   );

   // Group is complete when every PE has finished its pixel.
   assign group_done = &pix_done;
   assign m_tvalid   = group_done;

   // PE i handles column col_base + i.
   for (genvar i = 0; i < `NUM_PE; i++) begin : g_pe
      mandel_pe #(
         .PE_IDX (i)
      ) u_mandel_pe (
         .clk        (clk),
         .reset      (reset),
         .scan_clear (scan_clear),
         .group_done (group_done),
         .col_base   (col_base),
         .row        (row),
         .min_x      (min_x),
         .min_y      (min_y),
         .step_x     (step_x),
         .step_y     (step_y),
         .max_depth  (max_depth),
         .pix_done   (pix_done[i]),
         .depth      (pe_depth[i])
      );

      assign m_tdata[i*`DEPTH_W +: `DEPTH_W] = pe_depth[i];
   end

endmodule

/* tests/tb_mandel_top.sv */
/*
 * Testbench for the Mandelbrot renderer.
 * Replays config words and frames from the stim file and checks every group.
 */

`timescale 1ns/1ps

`include "mandel_config.svh"

module tb_mandel_top;

   localparam int DW = `NUM_PE * `DEPTH_W;
   localparam int QUIET_CYCLES = 100;

   logic                   clk;
   logic                   reset;
   logic                   start;
   logic                   s_tvalid;
   logic [`CFG_W-1:0]      s_tdata;
   logic                   m_tvalid;
   logic [DW-1:0]          m_tdata;

   // Parsed stim file.
   byte                    op_q[$];
   logic [`CFG_W-1:0]      cfg_q[$];
   logic [DW-1:0]          exp_q[$];

   logic [`CFG_W-1:0]      word;
   logic [`CFG_W-1:0]      cur_cfg;
   logic [63:0]            field;
   logic [DW-1:0]          grp;
   logic [DW-1:0]          exp_grp;
   logic [31:0]            lfsr;
   byte                    op;
   int                     fd, r, d, k, g, gap, col, row, ch;
   int                     n_groups, n_frames, frame_no, seen;
   int                     size_x, size_y, max_depth;
   int                     errors, err_mark, tests_ok, tests_bad;
   longint                 work, limit, cycles;
   real                    min_x, min_y, step_x, step_y, c_re, c_im;

   mandel_top u_mandel_top (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .s_tvalid (s_tvalid),
      .s_tdata  (s_tdata),
      .m_tvalid (m_tvalid),
      .m_tdata  (m_tdata)
   );

   // 4 ns clock.
   initial clk = 1'b0;
   always #2 clk = ~clk;

   // Cycle counter and run limit.
   initial begin
      cycles = 0;
      wait (limit != 0);
      while (cycles < limit) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("Timeout: DUT did not finish the frames within %0d cycles", limit);
      $display("SIMULATION FAILED");
      $finish;
   end

   // Fibonacci LFSR with taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic check(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
      if (exp !== act) begin
         $display("ERR t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
         errors = errors + 1;
      end
   endtask

   task automatic close_test(input string name);
      if (errors == err_mark) begin
         $display("test %s: ok", name);
         tests_ok = tests_ok + 1;
      end else begin
         $display("test %s: %0d errors", name, errors - err_mark);
         tests_bad = tests_bad + 1;
      end
      err_mark = errors;
   endtask

   // Idle cycles with no group output.
   task automatic expect_quiet(input int n);
      repeat (n) begin
         @(negedge clk);
         check("m_tvalid", '0, DW'(m_tvalid));
      end
   endtask

   // Decode config fields for the pixel rules.
   task automatic load_view(input logic [`CFG_W-1:0] w);
      min_x     = $bitstoreal(w[0*64 +: 64]);
      min_y     = $bitstoreal(w[1*64 +: 64]);
      step_x    = $bitstoreal(w[2*64 +: 64]);
      step_y    = $bitstoreal(w[3*64 +: 64]);
      size_x    = w[4*64 +: 32];
      size_y    = w[5*64 +: 32];
      max_depth = w[6*64 +: 32];
   endtask

   // Origin gives max depth. Any |re| >= 2.0 escapes at once.
   task automatic check_bounds(input int c0, input int rw, input logic [DW-1:0] act);
      int i;
      for (i = 0; i < `NUM_PE; i++) begin
         c_re = min_x + step_x * (c0 + i);
         c_im = min_y + step_y * rw;
         if (c_re == 0.0 && c_im == 0.0) begin
            check("origin depth", DW'(max_depth), DW'(act[i*`DEPTH_W +: `DEPTH_W]));
         end else if (c_re >= 2.0 || c_re <= -2.0) begin
            check("outside depth", DW'(1), DW'(act[i*`DEPTH_W +: `DEPTH_W]));
         end
      end
   endtask

   initial begin
      reset = 1'b1;
      start = 1'b0;
      s_tvalid = 1'b0;
      s_tdata = '0;
      errors = 0;
      err_mark = 0;
      tests_ok = 0;
      tests_bad = 0;
      limit = 0;
      work = 0;
      n_frames = 0;
      lfsr = 32'h7985_6611;

      // ====================
      // Stim file
      // ====================
      fd = $fopen("tests/mandel_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stim file tests/mandel_stim.txt");
         errors = errors + 1;
      end else begin
         while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", op);
            if (r != 1) begin
               break;
            end
            if (op == "#") begin
               // Skip the rest of a comment line.
               ch = $fgetc(fd);
               while (ch != "\n" && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end else if (op == "C") begin
               for (k = 0; k < 8; k++) begin
                  r = $fscanf(fd, " %h", field);
                  word[k*64 +: 64] = field;
               end
               cfg_q.push_back(word);
               op_q.push_back(op);
               load_view(word);
            end else if (op == "S") begin
               op_q.push_back(op);
               // Worst case per group is max depth plus load and output cycles.
               work = work + (size_x / `NUM_PE) * size_y * (max_depth + 2);
               n_frames = n_frames + 1;
            end else if (op == "E") begin
               for (k = 0; k < `NUM_PE; k++) begin
                  r = $fscanf(fd, " %d", d);
                  grp[k*`DEPTH_W +: `DEPTH_W] = d;
               end
               exp_q.push_back(grp);
            end
         end
         $fclose(fd);
      end
      limit = work + n_frames * (QUIET_CYCLES + 16 + 10) + 16 + 200;

      // ====================
      // Reset
      // ====================
      // Held over 16 rising edges.
      repeat (15) begin
         @(negedge clk);
         check("m_tvalid", '0, DW'(m_tvalid));
      end
      @(posedge clk);
      #0.5 reset = 1'b0;

      frame_no = 0;
      foreach (op_q[n]) begin
         if (op_q[n] == "C") begin
            cur_cfg = cfg_q.pop_front();
            @(posedge clk);
            #0.5;
            s_tvalid = 1'b1;
            s_tdata = cur_cfg;
            @(posedge clk);
            #0.5 s_tvalid = 1'b0;
            load_view(cur_cfg);
         end else begin
            // Random idle gap before start.
            gap = 0;
            for (k = 0; k < 4; k++) begin
               lfsr = lfsr_next(lfsr);
               gap = (gap << 1) | int'(lfsr[0]);
            end
            expect_quiet(gap + 1);
            if (frame_no == 0) begin
               close_test("reset_idle");
            end
            frame_no = frame_no + 1;
            @(posedge clk);
            #0.5 start = 1'b1;
            @(posedge clk);
            #0.5 start = 1'b0;
            n_groups = (size_x / `NUM_PE) * size_y;
            col = 0;
            row = 0;
            for (g = 0; g < n_groups; g++) begin
               @(negedge clk);
               while (!m_tvalid) begin
                  @(negedge clk);
               end
               if (exp_q.size() == 0) begin
                  $display("Stim file has no expected row left for frame %0d", frame_no);
                  errors = errors + 1;
                  exp_grp = 'x;
               end else begin
                  exp_grp = exp_q.pop_front();
               end
               check("m_tdata", exp_grp, m_tdata);
               check_bounds(col, row, m_tdata);
               col = col + `NUM_PE;
               if (col >= size_x) begin
                  col = 0;
                  row = row + 1;
               end
            end
            // No extra group after the frame ends.
            seen = 0;
            repeat (QUIET_CYCLES) begin
               @(negedge clk);
               if (m_tvalid) begin
                  seen = seen + 1;
               end
            end
            if (seen != 0) begin
               $display("Frame %0d gave %0d groups after its last one", frame_no, seen);
               errors = errors + 1;
            end
            close_test($sformatf("frame_%0d", frame_no));
         end
      end

      $display("done: %0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* tests/mandel_stim.txt */
# C: min_x min_y step_x step_y size_x size_y max_depth unused (64-bit hex fields)
# S: start a frame.  E: expected depths of PE 0..NUM_PE-1 for one group, decimal
C C000000000000000 0000000000000000 3FE0000000000000 4000000000000000 0000000000000008 0000000000000002 0000000000000014 0000000000000000
S
# Frame 1, row 0 on the real axis.
E 1 20 20 20
E 20 5 3 2
# Row 1 sits at im 2.0.
E 1 1 1 1
E 1 1 1 1
C C000000000000000 0000000000000000 3FF0000000000000 3FF0000000000000 0000000000000004 0000000000000003 0000000000000007 0000000000000000
S
# Frame 2, rows at im 0, 1 and 2.
E 1 7 7 3
E 1 3 7 2
E 1 1 1 1

/* mandel_top.f */
+incdir+verilog
verilog/fixed_pkg.sv
verilog/frame_pkg.sv
verilog/view_config.sv
verilog/frame_sequencer.sv
verilog/pixel_coord.sv
verilog/mandel_pe.sv
verilog/mandel_top.sv
tests/tb_mandel_top.sv

/* Bender.yml */
package:
  name: mandel_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fixed_pkg.sv
      - verilog/frame_pkg.sv
      - verilog/view_config.sv
      - verilog/frame_sequencer.sv
      - verilog/pixel_coord.sv
      - verilog/mandel_pe.sv
      - verilog/mandel_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_mandel_top.sv
